// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_alu_exec_unit
FILELIST  := sim.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard design/*.sv design/*.svh testbench/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/adder.sv ====
`timescale 1ns/1ps
`include "alu_defs.svh"

module adder (
  input  logic [`ALU_WIDTH-1:0] a,
  input  logic [`ALU_WIDTH-1:0] b,     // Already inverted on subtract
  input  logic                  cin,
  input  alu_pkg::alu_op_t      op,
  output logic                  carry,
  output logic                  overflow,
  output logic                  zero,
  output logic [`ALU_WIDTH-1:0] sum
);

  logic is_sub;
  logic b_sign;
  logic sum_flip;

  cla_adder32 u_cla_adder32 (.a(a), .b(b), .cin(cin), .sum(sum), .cout(carry));

  assign is_sub   = ((op[3:2] == 2'b00) && op[1]) || (op[3:2] == 2'b10);
  assign b_sign   = b[`ALU_WIDTH-1] ^ is_sub;   // Sign of the original b
  assign sum_flip = sum[`ALU_WIDTH-1] != a[`ALU_WIDTH-1];

  // Raw signed overflow, masked per op in the ALU
  assign overflow = (!is_sub && (a[`ALU_WIDTH-1] == b_sign) && sum_flip)
                 || (is_sub && (a[`ALU_WIDTH-1] != b_sign) && sum_flip);

  assign zero = ~|sum;

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps
`include "alu_defs.svh"

module alu (
  input  logic [`ALU_WIDTH-1:0] a,
  input  logic [`ALU_WIDTH-1:0] b,
  input  alu_pkg::alu_op_t      op,
  output logic [`ALU_WIDTH-1:0] result,
  output logic                  zero,
  output logic                  overflow
);

  logic                  sub;
  logic                  sig;
  logic                  ovf_en;
  alu_pkg::alu_group_t   grp;
  alu_pkg::shift_kind_t  kind;

  logic [`ALU_WIDTH-1:0] b_cond;
  logic [`ALU_WIDTH-1:0] add_sum;
  logic                  add_carry;
  logic                  add_ovf;

  logic [`ALU_WIDTH-1:0] logic_res;
  logic [`ALU_WIDTH-1:0] shift_res;
  logic [`ALU_WIDTH-1:0] slt_res;
  logic                  less;

  // Subtract for SUBU, SUB and the compares
  assign sub    = ((op[3:2] == 2'b00) && op[1]) || (op[3:2] == 2'b10);
  assign sig    = op[0];
  assign ovf_en = (op == alu_pkg::ADD) || (op == alu_pkg::SUB);
  assign grp    = alu_pkg::alu_group_t'(op[3:2]);
  assign kind   = alu_pkg::shift_kind_t'(op[1:0]);

  assign b_cond = b ^ {`ALU_WIDTH{sub}};

  adder u_adder (
    .a        (a),
    .b        (b_cond),
    .cin      (sub),
    .op       (op),
    .carry    (add_carry),
    .overflow (add_ovf),
    .zero     (zero),
    .sum      (add_sum)
  );

  shifter u_shifter (
    .a       (a),
    .shamt   (b[`ALU_SHAMT_WIDTH-1:0]),
    .kind    (kind),
    .shifted (shift_res)
  );

  always_comb
  begin
    case (op[1:0])
      2'b00:   logic_res = a & b;
      2'b01:   logic_res = a | b;
      2'b10:   logic_res = a ^ b;
      default: logic_res = ~(a | b);
    endcase
  end

  // No carry out means a < b when unsigned
  assign less    = sig ? (add_ovf ^ add_sum[`ALU_WIDTH-1]) : (add_carry ^ sub);
  assign slt_res = {{(`ALU_WIDTH-1){1'b0}}, less};

  assign overflow = add_ovf & ovf_en;

  always_comb
  begin
    case (grp)
      alu_pkg::ARITH:   result = add_sum;
      alu_pkg::LOGIC:   result = logic_res;
      alu_pkg::COMPARE: result = slt_res;
      default:          result = shift_res;
    endcase
  end

endmodule

// ==== design/alu_defs.svh ====
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// Datapath width of the execute unit
`define ALU_WIDTH 32

// Shift amount taken from the low bits of operand b
`define ALU_SHAMT_WIDTH 5

`endif

// ==== design/alu_exec_unit.sv ====
`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_exec_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req,
  input  alu_pkg::alu_op_t      op,
  input  logic [`ALU_WIDTH-1:0] a,
  input  logic [`ALU_WIDTH-1:0] b,
  output logic                  ack,
  output logic [`ALU_WIDTH-1:0] result,
  output logic                  zero,
  output logic                  overflow
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,   // Operands held, ALU settling
    ST_DONE    // Ack high until req drops
  } state_t;

  state_t                state;
  state_t                state_nxt;

  alu_pkg::alu_op_t      op_q;
  logic [`ALU_WIDTH-1:0] a_q;
  logic [`ALU_WIDTH-1:0] b_q;

  logic [`ALU_WIDTH-1:0] alu_result;
  logic                  alu_zero;
  logic                  alu_overflow;

  alu u_alu (
    .a        (a_q),
    .b        (b_q),
    .op       (op_q),
    .result   (alu_result),
    .zero     (alu_zero),
    .overflow (alu_overflow)
  );

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE: if (req) state_nxt = ST_BUSY;
      ST_BUSY: state_nxt = ST_DONE;
      ST_DONE: if (!req) state_nxt = ST_IDLE;
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state <= ST_IDLE;
    else
      state <= state_nxt;
  end

  always_ff @(posedge clk)
  begin
    if (state == ST_IDLE && req)   // Requester holds these until ack
    begin
      op_q <= op;
      a_q  <= a;
      b_q  <= b;
    end
  end

  // Outputs stay put through done and idle
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      result   <= '0;
      zero     <= 1'b0;
      overflow <= 1'b0;
    end
    else if (state == ST_BUSY)
    begin
      result   <= alu_result;
      zero     <= alu_zero;
      overflow <= alu_overflow;
    end
  end

  assign ack = (state == ST_DONE);

endmodule

// ==== design/alu_pkg.sv ====
package alu_pkg;

  // Operation codes, upper two bits select the result group
  typedef enum logic [3:0] {
    ADDU  = 4'b0000,
    ADD   = 4'b0001,  // Overflow flagged
    SUBU  = 4'b0010,
    SUB   = 4'b0011,  // Overflow flagged
    AND   = 4'b0100,
    OR    = 4'b0101,
    XOR   = 4'b0110,
    NOR   = 4'b0111,
    SLTU  = 4'b1000,
    SLT   = 4'b1001,
    SLL   = 4'b1100,
    SRL   = 4'b1101,
    SRA   = 4'b1110,
    PASSA = 4'b1111
  } alu_op_t;

  typedef enum logic [1:0] {
    ARITH,
    LOGIC,
    COMPARE,
    SHIFT
  } alu_group_t;

  // Low two op bits inside the shift group
  typedef enum logic [1:0] {
    SHIFT_SLL,
    SHIFT_SRL,
    SHIFT_SRA,
    SHIFT_PASS
  } shift_kind_t;

endpackage

// ==== design/cla_4.sv ====
`timescale 1ns/1ps

module cla_4 (
  input  logic [3:0] p,
  input  logic [3:0] g,
  input  logic       c_in,
  output logic [4:1] c,
  output logic       gx,
  output logic       px
);

  assign c[1] = g[0] | (p[0] & c_in);
  assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & c_in);
  assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
              | (p[2] & p[1] & p[0] & c_in);
  assign c[4] = gx | (px & c_in);

  // Group terms for the next level up
  assign px = &p;
  assign gx = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
            | (p[3] & p[2] & p[1] & g[0]);

endmodule

// ==== design/cla_adder32.sv ====
`timescale 1ns/1ps
`include "alu_defs.svh"

module cla_adder32 (
  input  logic [`ALU_WIDTH-1:0] a,
  input  logic [`ALU_WIDTH-1:0] b,
  input  logic                  cin,
  output logic [`ALU_WIDTH-1:0] sum,
  output logic                  cout
);

  logic [31:0] g;
  logic [31:0] p;
  logic [32:1] c;     // Bit carries from the first level
  logic [7:0]  g_l1;
  logic [7:0]  p_l1;
  logic [8:1]  c_l1;  // Group carries, two halves
  logic [1:0]  g_l2;
  logic [1:0]  p_l2;
  logic [4:1]  c_l2;  // Root carries, only two used
  logic [7:0]  c_grp; // Carry into each nibble

  assign g = a & b;
  assign p = a | b;

  assign c_grp = {c_l1[7:5], c_l2[1], c_l1[3:1], cin};

  for (genvar i = 0; i < 8; i++)
  begin : g_nibble
    cla_4 u_cla (.p(p[4*i+3 -: 4]), .g(g[4*i+3 -: 4]), .c_in(c_grp[i]),
                 .c(c[4*i+4 -: 4]), .gx(g_l1[i]), .px(p_l1[i]));
  end

  cla_4 u_cla_lo (.p(p_l1[3:0]), .g(g_l1[3:0]), .c_in(cin),
                  .c(c_l1[4:1]), .gx(g_l2[0]), .px(p_l2[0]));
  cla_4 u_cla_hi (.p(p_l1[7:4]), .g(g_l1[7:4]), .c_in(c_l2[1]),
                  .c(c_l1[8:5]), .gx(g_l2[1]), .px(p_l2[1]));

  // Root cell, upper half of its inputs tied low
  cla_4 u_cla_root (.p({2'b00, p_l2}), .g({2'b00, g_l2}), .c_in(cin),
                    .c(c_l2), .gx(), .px());

  assign sum  = a ^ b ^ {c[31:1], cin};
  assign cout = c_l2[2];

endmodule

// ==== design/shifter.sv ====
`timescale 1ns/1ps
`include "alu_defs.svh"

module shifter (
  input  logic [`ALU_WIDTH-1:0]       a,
  input  logic [`ALU_SHAMT_WIDTH-1:0] shamt,
  input  alu_pkg::shift_kind_t        kind,
  output logic [`ALU_WIDTH-1:0]       shifted
);

  logic [`ALU_WIDTH-1:0] sll_v;
  logic [`ALU_WIDTH-1:0] srl_v;
  logic [`ALU_WIDTH-1:0] sra_v;

  // One stage per shamt bit, stage i moves by 2**i
  always_comb
  begin
    sll_v = a;
    srl_v = a;
    sra_v = a;
    for (int i = 0; i < `ALU_SHAMT_WIDTH; i++)
    begin
      if (shamt[i])
      begin
        sll_v = sll_v << (1 << i);
        srl_v = srl_v >> (1 << i);
        sra_v = $signed(sra_v) >>> (1 << i);  // Sign fill
      end
    end
  end

  always_comb
  begin
    case (kind)
      alu_pkg::SHIFT_SLL: shifted = sll_v;
      alu_pkg::SHIFT_SRL: shifted = srl_v;
      alu_pkg::SHIFT_SRA: shifted = sra_v;
      default:            shifted = a;
    endcase
  end

endmodule

// ==== sim.f ====
+incdir+design
design/alu_pkg.sv
design/cla_4.sv
design/cla_adder32.sv
design/adder.sv
design/shifter.sv
design/alu.sv
design/alu_exec_unit.sv
testbench/tb_clock_gen.sv
testbench/tb_alu_exec_unit.sv

// ==== testbench/tb_alu_exec_unit.sv ====
`timescale 1ns/1ps
`include "alu_defs.svh"

module tb_alu_exec_unit;

  localparam int    TIMEOUT_CYCLES = 8000;  // ~700 transactions, at most 8 cycles each
  localparam int    ACK_WAIT_LIMIT = 16;
  localparam longint MAX_S32       = 64'sd2147483647;
  localparam longint MIN_S32       = -64'sd2147483648;

  logic                  clk;
  logic                  rst_n;
  logic                  req;
  alu_pkg::alu_op_t      op;
  logic [`ALU_WIDTH-1:0] a;
  logic [`ALU_WIDTH-1:0] b;
  logic                  ack;
  logic [`ALU_WIDTH-1:0] result;
  logic                  zero;
  logic                  overflow;

  logic [`ALU_WIDTH-1:0] exp_result_q[$];
  logic                  exp_zero_q[$];
  logic                  exp_ovf_q[$];

  int error_count;
  int check_count;
  int txn_count;
  int cycle_count;

  tb_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));

  alu_exec_unit u_alu_exec_unit (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .op       (op),
    .a        (a),
    .b        (b),
    .ack      (ack),
    .result   (result),
    .zero     (zero),
    .overflow (overflow)
  );

  // Expected outputs straight from the op definitions
  function automatic void compute_expected(
    input  logic [3:0]            code,
    input  logic [`ALU_WIDTH-1:0] a_in,
    input  logic [`ALU_WIDTH-1:0] b_in,
    output logic [`ALU_WIDTH-1:0] res,
    output logic                  zf,
    output logic                  of
  );
    logic [`ALU_WIDTH-1:0] add_out;
    logic                  sub_path;
    alu_pkg::alu_group_t   grp;
    longint                wide;
    grp      = alu_pkg::alu_group_t'(code[3:2]);
    // SUBU, SUB and every compare code subtract
    sub_path = (code == 4'b0010) || (code == 4'b0011) || (grp == alu_pkg::COMPARE);
    add_out  = sub_path ? a_in - b_in : a_in + b_in;
    zf       = (add_out == '0);  // Adder output, any op
    of       = 1'b0;
    if (code == 4'b0001 || code == 4'b0011)
    begin
      if (code == 4'b0001)
        wide = longint'($signed(a_in)) + longint'($signed(b_in));
      else
        wide = longint'($signed(a_in)) - longint'($signed(b_in));
      of = (wide > MAX_S32) || (wide < MIN_S32);
    end
    res = '0;
    case (code)
      4'b0000, 4'b0001: res = a_in + b_in;
      4'b0010, 4'b0011: res = a_in - b_in;
      4'b0100:          res = a_in & b_in;
      4'b0101:          res = a_in | b_in;
      4'b0110:          res = a_in ^ b_in;
      4'b0111:          res = ~(a_in | b_in);
      4'b1000, 4'b1010: res[0] = a_in < b_in;
      4'b1001, 4'b1011: res[0] = $signed(a_in) < $signed(b_in);
      4'b1100:          res = a_in << b_in[`ALU_SHAMT_WIDTH-1:0];
      4'b1101:          res = a_in >> b_in[`ALU_SHAMT_WIDTH-1:0];
      4'b1110:          res = $signed(a_in) >>> b_in[`ALU_SHAMT_WIDTH-1:0];
      default:          res = a_in;
    endcase
  endfunction

  task automatic check_value(
    input string       name,
    input logic [31:0] expected,
    input logic [31:0] actual
  );
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // One four-phase transaction, entered on a falling edge with ack low
  task automatic run_op(
    input logic [3:0]            code,
    input logic [`ALU_WIDTH-1:0] a_in,
    input logic [`ALU_WIDTH-1:0] b_in
  );
    logic [`ALU_WIDTH-1:0] exp_res;
    logic                  exp_z;
    logic                  exp_o;
    logic [`ALU_WIDTH-1:0] held_res;
    logic                  held_z;
    logic                  held_o;
    int                    edges;
    int                    hold;
    compute_expected(code, a_in, b_in, exp_res, exp_z, exp_o);
    exp_result_q.push_back(exp_res);
    exp_zero_q.push_back(exp_z);
    exp_ovf_q.push_back(exp_o);
    op  = alu_pkg::alu_op_t'(code);
    a   = a_in;
    b   = b_in;
    req = 1'b1;
    @(posedge clk);
    edges = 1;
    @(negedge clk);
    while (!ack && edges < ACK_WAIT_LIMIT)
    begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    if (!ack)
    begin
      error_count++;
      $display("Ack never rose within %0d cycles of req at %0t", ACK_WAIT_LIMIT, $time);
      req = 1'b0;
      return;
    end
    check_value("ack_latency", 32'd2, edges);
    held_res = result;
    held_z   = zero;
    held_o   = overflow;
    hold = $urandom_range(0, 5);
    repeat (hold)
    begin
      @(negedge clk);
      check_value("ack", 32'd1, 32'(ack));
      check_value("result_held", held_res, result);
      check_value("zero_held", 32'(held_z), 32'(zero));
      check_value("overflow_held", 32'(held_o), 32'(overflow));
    end
    req = 1'b0;
    a   = $urandom;  // Bus free once req is low
    b   = $urandom;
    @(posedge clk);
    @(negedge clk);
    check_value("ack", 32'd0, 32'(ack));
    txn_count++;
  endtask

  // Compare process, samples one falling edge after ack rises
  always
  begin
    @(posedge ack);
    @(negedge clk);
    if (exp_result_q.size() == 0)
    begin
      error_count++;
      $display("Ack rose at %0t with no request outstanding", $time);
    end
    else
    begin
      check_value("result", exp_result_q.pop_front(), result);
      check_value("zero", 32'(exp_zero_q.pop_front()), 32'(zero));
      check_value("overflow", 32'(exp_ovf_q.pop_front()), 32'(overflow));
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles with %0d transactions done", cycle_count, txn_count);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial
  begin
    logic [31:0] rnd;
    logic [31:0] rnd_b;
    logic [3:0]  code;
    error_count = 0;
    check_count = 0;
    txn_count   = 0;
    cycle_count = 0;
    req = 1'b0;
    op  = alu_pkg::ADDU;
    a   = '0;
    b   = '0;
    void'($urandom(32'h6421_7800));

    wait (rst_n);
    @(negedge clk);
    check_value("ack_reset", 32'd0, 32'(ack));
    check_value("result_reset", 32'd0, result);
    check_value("zero_reset", 32'd0, 32'(zero));
    check_value("overflow_reset", 32'd0, 32'(overflow));

    // Arithmetic corners
    run_op(alu_pkg::ADD,  32'h7fff_ffff, 32'h0000_0001);
    run_op(alu_pkg::ADDU, 32'h7fff_ffff, 32'h0000_0001);
    run_op(alu_pkg::SUB,  32'h8000_0000, 32'h0000_0001);
    run_op(alu_pkg::SUBU, 32'h8000_0000, 32'h0000_0001);
    run_op(alu_pkg::ADD,  32'hffff_ffff, 32'h0000_0001);
    run_op(alu_pkg::ADDU, 32'hffff_ffff, 32'h0000_0001);
    run_op(alu_pkg::SUB,  32'h1234_5678, 32'h1234_5678);
    run_op(alu_pkg::SUBU, 32'hdead_beef, 32'hdead_beef);
    run_op(alu_pkg::ADD,  32'h8000_0000, 32'h8000_0000);
    run_op(alu_pkg::SUB,  32'h7fff_ffff, 32'hffff_ffff);
    run_op(alu_pkg::SUB,  32'h0000_0000, 32'h8000_0000);
    run_op(alu_pkg::ADD,  32'h0000_0000, 32'h0000_0000);
    for (int i = 0; i < 40; i++)
    begin
      for (int k = 0; k < 4; k++)
        run_op(4'(k), $urandom, $urandom);
    end
    for (int i = 0; i < 4; i++)
    begin
      rnd = $urandom;
      run_op(alu_pkg::SUB, rnd, rnd);
      run_op(alu_pkg::SUBU, rnd, rnd);
    end

    // Logic ops
    for (int k = 4; k < 8; k++)
    begin
      run_op(4'(k), 32'h0000_0000, 32'h0000_0000);
      run_op(4'(k), 32'hffff_ffff, 32'hffff_ffff);
      run_op(4'(k), 32'hffff_ffff, 32'h0000_0000);
      run_op(4'(k), 32'h0000_0000, 32'hffff_ffff);
      for (int i = 0; i < 30; i++)
        run_op(4'(k), $urandom, $urandom);
    end

    // Compares, 1010 and 1011 alias SLTU and SLT
    for (int k = 8; k < 10; k++)
    begin
      run_op(4'(k), 32'hffff_ffff, 32'h0000_0001);
      run_op(4'(k), 32'h0000_0001, 32'hffff_ffff);
      run_op(4'(k), 32'h8000_0000, 32'h7fff_ffff);
      run_op(4'(k), 32'h7fff_ffff, 32'h8000_0000);
      run_op(4'(k), 32'h0000_0005, 32'h0000_0005);
      run_op(4'(k), 32'h8000_0000, 32'h8000_0000);
      for (int i = 0; i < 30; i++)
        run_op(4'(k), $urandom, $urandom);
    end
    run_op(4'b1010, 32'hffff_ffff, 32'h0000_0001);
    run_op(4'b1011, 32'hffff_ffff, 32'h0000_0001);
    run_op(4'b1010, $urandom, $urandom);
    run_op(4'b1011, $urandom, $urandom);

    // Shifts, upper bits of b are noise
    for (int k = 12; k < 16; k++)
    begin
      for (int sh = 0; sh < 32; sh++)
      begin
        rnd   = $urandom;
        rnd_b = $urandom;
        rnd_b[4:0] = 5'(sh);
        run_op(4'(k), rnd | 32'h8000_0000, rnd_b);
        run_op(4'(k), rnd & 32'h7fff_ffff, rnd_b);
      end
    end

    for (int i = 0; i < 50; i++)
    begin
      rnd  = $urandom;
      code = rnd[3:0];
      run_op(code, $urandom, $urandom);
    end

    if (exp_result_q.size() != 0)
    begin
      error_count++;
      $display("%0d expected results were never compared", exp_result_q.size());
    end

    $display("Transactions: %0d, checks: %0d, errors: %0d", txn_count, check_count,
             error_count);
    if (error_count == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 10;  // 20 ns clock
  localparam int RESET_CYCLES = 4;

  initial
  begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Released on a falling edge, clear of the sampling edge
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule
